/* hw/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// bus widths shared by the whole read bridge
`define MMU_ADDR_W 32
`define MMU_DATA_W 32
`define MMU_ID_W 4

// number of read requests the address queue holds, a power of two
`define MMU_AR_DEPTH 8

`endif

/* hw/axi_pkg.sv */
`default_nettype none

`include "mmu_defines.svh"

package axi_pkg;

    typedef logic [`MMU_ADDR_W-1:0] addr_t;
    typedef logic [`MMU_DATA_W-1:0] data_t;
    typedef logic [`MMU_ID_W-1:0]   id_t;

    typedef logic [7:0] len_t;   // beats in the burst minus one
    typedef logic [2:0] size_t;  // bytes per beat as a power of two
    typedef logic [1:0] burst_t;
    typedef logic [2:0] prot_t;

    // read response codes as seen on RRESP
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

/* hw/xlat_pkg.sv */
`default_nettype none

`include "mmu_defines.svh"

package xlat_pkg;

    typedef logic [`MMU_ADDR_W-1:0] vaddr_t;
    typedef logic [7:0]             xlen_t;
    typedef logic [2:0]             xsize_t;

    // word sent to the translation unit, size sits in the top bits
    typedef struct packed {
        xsize_t size;
        xlen_t  len;
        vaddr_t vaddr;
    } xlat_req_t;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        REQ  = 3'd1,  // request offered to the translation unit
        WAIT = 3'd2,  // waiting for done or drop
        FWD  = 3'd3,
        DROP = 3'd4
    } xlat_state_t;

endpackage

`default_nettype wire

/* hw/ar_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// head entry of the read address queue as seen by the controller
interface ar_req_if;

    axi_pkg::id_t    id;
    axi_pkg::addr_t  addr;
    axi_pkg::len_t   len;
    axi_pkg::size_t  size;
    axi_pkg::burst_t burst;
    axi_pkg::prot_t  prot;
    logic            valid;  // queue holds at least one entry
    logic            pop;    // one cycle pulse frees the head entry

    modport queue (
        output id, addr, len, size, burst, prot, valid,
        input  pop
    );

    modport ctrl (
        input  id, addr, len, size, burst, prot, valid,
        output pop
    );

endinterface

`default_nettype wire

/* hw/drop_if.sv */
`timescale 1ns/1ps
`default_nettype none

// a request the translation unit refused, handed to the read return
interface drop_if;

    axi_pkg::id_t  id;
    axi_pkg::len_t len;
    logic          valid;
    logic          ready;  // read return is idle and nothing is outstanding

    modport ctrl (
        output id, len, valid,
        input  ready
    );

    modport ret (
        input  id, len, valid,
        output ready
    );

endinterface

`default_nettype wire

/* hw/ar_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module ar_queue #(
    parameter int DEPTH = `MMU_AR_DEPTH
) (
    input  wire                  s_axi_clk,
    input  wire                  s_aresetn,
    input  wire axi_pkg::id_t    s_axi_arid,
    input  wire axi_pkg::addr_t  s_axi_araddr,
    input  wire axi_pkg::len_t   s_axi_arlen,
    input  wire axi_pkg::size_t  s_axi_arsize,
    input  wire axi_pkg::burst_t s_axi_arburst,
    input  wire axi_pkg::prot_t  s_axi_arprot,
    input  wire                  s_axi_arvalid,
    output logic                 s_axi_arready,
    ar_req_if.queue              head
);

    localparam int PTR_W = $clog2(DEPTH);

    axi_pkg::id_t    id_mem    [DEPTH];
    axi_pkg::addr_t  addr_mem  [DEPTH];
    axi_pkg::len_t   len_mem   [DEPTH];
    axi_pkg::size_t  size_mem  [DEPTH];
    axi_pkg::burst_t burst_mem [DEPTH];
    axi_pkg::prot_t  prot_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // one bit wider so a full queue is distinct from empty
    logic             push;
    logic             pop;

    assign s_axi_arready = (count != (PTR_W+1)'(DEPTH));
    assign push          = s_axi_arvalid && s_axi_arready;
    assign pop           = head.pop && head.valid;  // a pop on an empty queue is ignored

    always_ff @(posedge s_axi_clk) begin
        if (push) begin
            id_mem[wr_ptr]    <= s_axi_arid;
            addr_mem[wr_ptr]  <= s_axi_araddr;
            len_mem[wr_ptr]   <= s_axi_arlen;
            size_mem[wr_ptr]  <= s_axi_arsize;
            burst_mem[wr_ptr] <= s_axi_arburst;
            prot_mem[wr_ptr]  <= s_axi_arprot;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the fill level alone
            endcase
        end
    end

    // the head entry is read straight out of the array
    assign head.valid = (count != '0);
    assign head.id    = id_mem[rd_ptr];
    assign head.addr  = addr_mem[rd_ptr];
    assign head.len   = len_mem[rd_ptr];
    assign head.size  = size_mem[rd_ptr];
    assign head.burst = burst_mem[rd_ptr];
    assign head.prot  = prot_mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/xlat_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module xlat_ctrl (
    input  wire                  s_axi_clk,
    input  wire                  s_aresetn,
    ar_req_if.ctrl               head,
    output logic                 xlat_req_valid,
    input  wire                  xlat_req_ready,
    output xlat_pkg::xlat_req_t  xlat_req_data,
    input  wire                  xlat_resp_valid,
    output logic                 xlat_resp_ready,
    input  wire                  xlat_resp_done,
    input  wire axi_pkg::addr_t  xlat_resp_addr,
    output axi_pkg::id_t         m_axi_arid,
    output axi_pkg::addr_t       m_axi_araddr,
    output axi_pkg::len_t        m_axi_arlen,
    output axi_pkg::size_t       m_axi_arsize,
    output axi_pkg::burst_t      m_axi_arburst,
    output axi_pkg::prot_t       m_axi_arprot,
    output logic                 m_axi_arvalid,
    input  wire                  m_axi_arready,
    output logic                 ar_sent,
    drop_if.ctrl                 drop
);

    xlat_pkg::xlat_state_t state;

    // every handshake output is decoded from the state alone
    assign xlat_req_valid  = (state == xlat_pkg::REQ);
    assign xlat_resp_ready = (state == xlat_pkg::WAIT);
    assign m_axi_arvalid   = (state == xlat_pkg::FWD);
    assign drop.valid      = (state == xlat_pkg::DROP);

    // a dropped request reuses the id and length held for the outgoing AR
    assign drop.id  = m_axi_arid;
    assign drop.len = m_axi_arlen;

    assign ar_sent  = m_axi_arvalid && m_axi_arready;
    assign head.pop = ar_sent || (drop.valid && drop.ready);  // head leaves at either end

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            state <= xlat_pkg::IDLE;
        end else begin
            case (state)
                xlat_pkg::IDLE: begin
                    if (head.valid) begin
                        state <= xlat_pkg::REQ;
                    end
                end
                xlat_pkg::REQ: begin
                    if (xlat_req_ready) begin
                        state <= xlat_pkg::WAIT;
                    end
                end
                xlat_pkg::WAIT: begin
                    if (xlat_resp_valid) begin
                        state <= xlat_resp_done ? xlat_pkg::FWD : xlat_pkg::DROP;
                    end
                end
                xlat_pkg::FWD: begin
                    if (m_axi_arready) begin
                        state <= xlat_pkg::IDLE;
                    end
                end
                xlat_pkg::DROP: begin
                    if (drop.ready) begin
                        state <= xlat_pkg::IDLE;
                    end
                end
                default: state <= xlat_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (state == xlat_pkg::IDLE && head.valid) begin
            m_axi_arid          <= head.id;
            m_axi_arlen         <= head.len;
            m_axi_arsize        <= head.size;
            m_axi_arburst       <= head.burst;
            m_axi_arprot        <= head.prot;
            xlat_req_data.size  <= head.size;
            xlat_req_data.len   <= head.len;
            xlat_req_data.vaddr <= head.addr;
        end
        // the physical address only counts when the answer is done
        if (state == xlat_pkg::WAIT && xlat_resp_valid && xlat_resp_done) begin
            m_axi_araddr <= xlat_resp_addr;
        end
    end

endmodule

`default_nettype wire

/* hw/r_return.sv */
`timescale 1ns/1ps
`default_nettype none

module r_return (
    input  wire                 s_axi_clk,
    input  wire                 s_aresetn,
    input  wire                 ar_sent,
    input  wire axi_pkg::id_t   m_axi_rid,
    input  wire axi_pkg::data_t m_axi_rdata,
    input  wire axi_pkg::resp_t m_axi_rresp,
    input  wire                 m_axi_rlast,
    input  wire                 m_axi_rvalid,
    output logic                m_axi_rready,
    output axi_pkg::id_t        s_axi_rid,
    output axi_pkg::data_t      s_axi_rdata,
    output axi_pkg::resp_t      s_axi_rresp,
    output logic                s_axi_rlast,
    output logic                s_axi_rvalid,
    input  wire                 s_axi_rready,
    drop_if.ret                 drop
);

    localparam int CNT_W = 8;  // outstanding forwarded bursts the counter can track

    logic [CNT_W-1:0] out_cnt;
    logic             rlast_hs;
    logic             err_active;
    axi_pkg::id_t     err_id;
    axi_pkg::len_t    err_left;  // error beats still to send after the current one

    assign rlast_hs = m_axi_rvalid && m_axi_rready && m_axi_rlast;

    // a drop waits until every forwarded burst has finished, which keeps request order
    assign drop.ready = !err_active && (out_cnt == '0);

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            out_cnt <= '0;
        end else begin
            case ({ar_sent, rlast_hs})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            err_active <= 1'b0;
        end else if (drop.valid && drop.ready) begin
            err_active <= 1'b1;
        end else if (err_active && s_axi_rready && err_left == '0) begin
            err_active <= 1'b0;  // last error beat taken
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (drop.valid && drop.ready) begin
            err_id   <= drop.id;
            err_left <= drop.len;
        end else if (err_active && s_axi_rready) begin
            err_left <= err_left - 1'b1;
        end
    end

    // memory data passes straight through unless an error burst owns the channel
    assign s_axi_rvalid = err_active ? 1'b1 : m_axi_rvalid;
    assign s_axi_rid    = err_active ? err_id : m_axi_rid;
    assign s_axi_rdata  = err_active ? '0 : m_axi_rdata;
    assign s_axi_rresp  = err_active ? axi_pkg::RESP_SLVERR : m_axi_rresp;
    assign s_axi_rlast  = err_active ? (err_left == '0) : m_axi_rlast;
    assign m_axi_rready = err_active ? 1'b0 : s_axi_rready;

endmodule

`default_nettype wire

/* hw/mmu_read_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_read_top (
    input  wire                       s_axi_clk,
    input  wire                       s_aresetn,
    // read address from the master
    input  wire axi_pkg::id_t         s_axi_arid,
    input  wire axi_pkg::addr_t       s_axi_araddr,
    input  wire axi_pkg::len_t        s_axi_arlen,
    input  wire axi_pkg::size_t       s_axi_arsize,
    input  wire axi_pkg::burst_t      s_axi_arburst,
    input  wire axi_pkg::prot_t       s_axi_arprot,
    input  wire                       s_axi_arvalid,
    output wire                       s_axi_arready,
    // read data back to the master
    output wire axi_pkg::id_t         s_axi_rid,
    output wire axi_pkg::data_t       s_axi_rdata,
    output wire axi_pkg::resp_t       s_axi_rresp,
    output wire                       s_axi_rlast,
    output wire                       s_axi_rvalid,
    input  wire                       s_axi_rready,
    // translated read address to the memory
    output wire axi_pkg::id_t         m_axi_arid,
    output wire axi_pkg::addr_t       m_axi_araddr,
    output wire axi_pkg::len_t        m_axi_arlen,
    output wire axi_pkg::size_t       m_axi_arsize,
    output wire axi_pkg::burst_t      m_axi_arburst,
    output wire axi_pkg::prot_t       m_axi_arprot,
    output wire                       m_axi_arvalid,
    input  wire                       m_axi_arready,
    // read data from the memory
    input  wire axi_pkg::id_t         m_axi_rid,
    input  wire axi_pkg::data_t       m_axi_rdata,
    input  wire axi_pkg::resp_t       m_axi_rresp,
    input  wire                       m_axi_rlast,
    input  wire                       m_axi_rvalid,
    output wire                       m_axi_rready,
    // translation unit
    output wire                       xlat_req_valid,
    input  wire                       xlat_req_ready,
    output wire xlat_pkg::xlat_req_t  xlat_req_data,
    input  wire                       xlat_resp_valid,
    output wire                       xlat_resp_ready,
    input  wire                       xlat_resp_done,
    input  wire axi_pkg::addr_t       xlat_resp_addr
);

    logic ar_sent;  // one forwarded burst now owes read data

    ar_req_if head_bus ();
    drop_if   drop_bus ();

    ar_queue u_ar_queue (
        .s_axi_clk     (s_axi_clk),
        .s_aresetn     (s_aresetn),
        .s_axi_arid    (s_axi_arid),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arlen   (s_axi_arlen),
        .s_axi_arsize  (s_axi_arsize),
        .s_axi_arburst (s_axi_arburst),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .head          (head_bus.queue)
    );

    xlat_ctrl u_xlat_ctrl (
        .s_axi_clk       (s_axi_clk),
        .s_aresetn       (s_aresetn),
        .head            (head_bus.ctrl),
        .xlat_req_valid  (xlat_req_valid),
        .xlat_req_ready  (xlat_req_ready),
        .xlat_req_data   (xlat_req_data),
        .xlat_resp_valid (xlat_resp_valid),
        .xlat_resp_ready (xlat_resp_ready),
        .xlat_resp_done  (xlat_resp_done),
        .xlat_resp_addr  (xlat_resp_addr),
        .m_axi_arid      (m_axi_arid),
        .m_axi_araddr    (m_axi_araddr),
        .m_axi_arlen     (m_axi_arlen),
        .m_axi_arsize    (m_axi_arsize),
        .m_axi_arburst   (m_axi_arburst),
        .m_axi_arprot    (m_axi_arprot),
        .m_axi_arvalid   (m_axi_arvalid),
        .m_axi_arready   (m_axi_arready),
        .ar_sent         (ar_sent),
        .drop            (drop_bus.ctrl)
    );

    r_return u_r_return (
        .s_axi_clk    (s_axi_clk),
        .s_aresetn    (s_aresetn),
        .ar_sent      (ar_sent),
        .m_axi_rid    (m_axi_rid),
        .m_axi_rdata  (m_axi_rdata),
        .m_axi_rresp  (m_axi_rresp),
        .m_axi_rlast  (m_axi_rlast),
        .m_axi_rvalid (m_axi_rvalid),
        .m_axi_rready (m_axi_rready),
        .s_axi_rid    (s_axi_rid),
        .s_axi_rdata  (s_axi_rdata),
        .s_axi_rresp  (s_axi_rresp),
        .s_axi_rlast  (s_axi_rlast),
        .s_axi_rvalid (s_axi_rvalid),
        .s_axi_rready (s_axi_rready),
        .drop         (drop_bus.ret)
    );

endmodule

`default_nettype wire

/* bench/tb_mmu_read.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_read;

    localparam int NUM_REQS       = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 64;  // roughly four times the expected run
    localparam int DROP_BIT       = 12;             // translation refuses any address with this bit set
    localparam axi_pkg::addr_t ADDR_MASK = 32'h4a5c_0000;

    typedef struct packed {
        axi_pkg::id_t    id;
        axi_pkg::addr_t  addr;
        axi_pkg::len_t   len;
        axi_pkg::size_t  size;
        axi_pkg::burst_t burst;
        axi_pkg::prot_t  prot;
    } rd_req_t;

    logic                s_axi_clk;
    logic                s_aresetn;
    axi_pkg::id_t        s_axi_arid;
    axi_pkg::addr_t      s_axi_araddr;
    axi_pkg::len_t       s_axi_arlen;
    axi_pkg::size_t      s_axi_arsize;
    axi_pkg::burst_t     s_axi_arburst;
    axi_pkg::prot_t      s_axi_arprot;
    logic                s_axi_arvalid;
    logic                s_axi_rready;
    logic                m_axi_arready;
    axi_pkg::id_t        m_axi_rid;
    axi_pkg::data_t      m_axi_rdata;
    axi_pkg::resp_t      m_axi_rresp;
    logic                m_axi_rlast;
    logic                m_axi_rvalid;
    logic                xlat_req_ready;
    logic                xlat_resp_valid;
    logic                xlat_resp_done;
    axi_pkg::addr_t      xlat_resp_addr;

    wire                      s_axi_arready;
    wire axi_pkg::id_t        s_axi_rid;
    wire axi_pkg::data_t      s_axi_rdata;
    wire axi_pkg::resp_t      s_axi_rresp;
    wire                      s_axi_rlast;
    wire                      s_axi_rvalid;
    wire axi_pkg::id_t        m_axi_arid;
    wire axi_pkg::addr_t      m_axi_araddr;
    wire axi_pkg::len_t       m_axi_arlen;
    wire axi_pkg::size_t      m_axi_arsize;
    wire axi_pkg::burst_t     m_axi_arburst;
    wire axi_pkg::prot_t      m_axi_arprot;
    wire                      m_axi_arvalid;
    wire                      m_axi_rready;
    wire                      xlat_req_valid;
    wire xlat_pkg::xlat_req_t xlat_req_data;
    wire                      xlat_resp_ready;

    integer         seed;
    int             cycle      = 0;
    int             issued     = 0;
    int             done_count = 0;
    int             xlat_wait  = 0;
    logic           xlat_busy  = 1'b0;  // a translation is being worked on
    axi_pkg::addr_t xlat_vaddr;
    axi_pkg::len_t  mem_beat   = '0;
    axi_pkg::len_t  r_beat     = '0;
    rd_req_t        cur_req;
    rd_req_t        resp_q[$];  // every accepted request in acceptance order
    rd_req_t        xlat_q[$];  // accepted requests not yet offered for translation
    rd_req_t        ar_q[$];    // only those that should reach the memory
    rd_req_t        mem_q[$];   // bursts the memory owes data for

    mmu_read_top dut0 (.*);

    task automatic fail_run;
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ar(input string name,
                            input axi_pkg::addr_t exp_addr, act_addr,
                            input axi_pkg::id_t exp_id, act_id,
                            input axi_pkg::len_t exp_len, act_len,
                            input axi_pkg::size_t exp_size, act_size,
                            input axi_pkg::burst_t exp_burst, act_burst,
                            input axi_pkg::prot_t exp_prot, act_prot);
        if ({exp_addr, exp_id, exp_len, exp_size, exp_burst, exp_prot} !==
            {act_addr, act_id, act_len, act_size, act_burst, act_prot}) begin
            $write("CHECK FAILED %s: expected addr=%h id=%h len=%0d size=%0d burst=%0d prot=%0d",
                   name, exp_addr, exp_id, exp_len, exp_size, exp_burst, exp_prot);
            $display(", actual addr=%h id=%h len=%0d size=%0d burst=%0d prot=%0d",
                     act_addr, act_id, act_len, act_size, act_burst, act_prot);
            fail_run();
        end
    endtask

    task automatic check_r(input string name,
                           input axi_pkg::id_t exp_id, act_id,
                           input axi_pkg::data_t exp_data, act_data,
                           input axi_pkg::resp_t exp_resp, act_resp,
                           input logic exp_last, act_last);
        if ({exp_id, exp_data, exp_resp, exp_last} !== {act_id, act_data, act_resp, act_last}) begin
            $write("CHECK FAILED %s: expected id=%h data=%h resp=%0d last=%b",
                   name, exp_id, exp_data, exp_resp, exp_last);
            $display(", actual id=%h data=%h resp=%0d last=%b",
                     act_id, act_data, act_resp, act_last);
            fail_run();
        end
    endtask

    task automatic check_xlat_req(input string name,
                                  input xlat_pkg::xlat_req_t exp_req, act_req);
        if (exp_req !== act_req) begin
            $write("CHECK FAILED %s: expected size=%0d len=%0d vaddr=%h",
                   name, exp_req.size, exp_req.len, exp_req.vaddr);
            $display(", actual size=%0d len=%0d vaddr=%h",
                     act_req.size, act_req.len, act_req.vaddr);
            fail_run();
        end
    endtask

    task automatic check_quiet(input string name, input logic rvalid, arvalid, req_valid);
        if ({rvalid, arvalid, req_valid} !== 3'b000) begin
            $display("CHECK FAILED %s: expected rvalid/arvalid/req_valid 000, actual %b%b%b",
                     name, rvalid, arvalid, req_valid);
            fail_run();
        end
    endtask

    // the master offers a new request only once the last one was taken
    task drive_master;
        if (s_axi_arvalid && s_axi_arready) begin
            resp_q.push_back(cur_req);
            xlat_q.push_back(cur_req);
            if (!cur_req.addr[DROP_BIT]) begin
                ar_q.push_back(cur_req);
            end
            s_axi_arvalid <= 1'b0;
        end
        if ((!s_axi_arvalid || s_axi_arready) && issued < NUM_REQS &&
            ($random(seed) & 1) != 0) begin
            cur_req.id    = axi_pkg::id_t'($random(seed));
            cur_req.addr  = axi_pkg::addr_t'($random(seed));
            cur_req.len   = axi_pkg::len_t'($unsigned($random(seed)) % 16);
            cur_req.size  = axi_pkg::size_t'($unsigned($random(seed)) % 3);
            cur_req.burst = axi_pkg::burst_t'($unsigned($random(seed)) % 3);
            cur_req.prot  = axi_pkg::prot_t'($random(seed));
            s_axi_arid    <= cur_req.id;
            s_axi_araddr  <= cur_req.addr;
            s_axi_arlen   <= cur_req.len;
            s_axi_arsize  <= cur_req.size;
            s_axi_arburst <= cur_req.burst;
            s_axi_arprot  <= cur_req.prot;
            s_axi_arvalid <= 1'b1;
            issued++;
        end
    endtask

    // translation unit answers one request at a time after a random delay
    task answer_xlat;
        rd_req_t             xreq;
        xlat_pkg::xlat_req_t exp_xreq;
        if (xlat_resp_valid && xlat_resp_ready) begin
            xlat_resp_valid <= 1'b0;
            xlat_busy = 1'b0;
        end else if (xlat_busy && !xlat_resp_valid) begin
            if (xlat_wait == 0) begin
                xlat_resp_valid <= 1'b1;
                xlat_resp_done  <= !xlat_vaddr[DROP_BIT];
                // on a drop the address is junk and must be ignored
                xlat_resp_addr  <= xlat_vaddr[DROP_BIT] ? axi_pkg::addr_t'($random(seed))
                                                        : xlat_vaddr ^ ADDR_MASK;
            end else begin
                xlat_wait--;
            end
        end
        if (xlat_req_valid && xlat_req_ready) begin
            if (xlat_q.size() == 0) begin
                $display("translation requested while no accepted request was waiting");
                fail_run();
            end else begin
                xreq           = xlat_q.pop_front();
                exp_xreq.size  = xreq.size;
                exp_xreq.len   = xreq.len;
                exp_xreq.vaddr = xreq.addr;
                check_xlat_req("xlat_req", exp_xreq, xlat_req_data);
            end
            xlat_vaddr = xlat_req_data.vaddr;
            xlat_wait  = $unsigned($random(seed)) % 8;
            xlat_busy  = 1'b1;
            xlat_req_ready <= 1'b0;
        end else if (!xlat_busy) begin
            xlat_req_ready <= ($random(seed) & 1) != 0;
        end
    endtask

    // memory returns physical address plus beat index and serves bursts in order
    task serve_memory;
        rd_req_t fwd;
        if (m_axi_arvalid && m_axi_arready) begin
            if (ar_q.size() == 0) begin
                $display("m_axi_ar issued while no forwarded request was pending");
                fail_run();
            end else begin
                fwd = ar_q.pop_front();
                check_ar("m_axi_ar", fwd.addr ^ ADDR_MASK, m_axi_araddr, fwd.id, m_axi_arid,
                         fwd.len, m_axi_arlen, fwd.size, m_axi_arsize,
                         fwd.burst, m_axi_arburst, fwd.prot, m_axi_arprot);
                mem_q.push_back(rd_req_t'{m_axi_arid, m_axi_araddr, m_axi_arlen,
                                          m_axi_arsize, m_axi_arburst, m_axi_arprot});
            end
        end
        m_axi_arready <= ($random(seed) & 1) != 0;
        if (m_axi_rvalid && m_axi_rready) begin
            if (m_axi_rlast) begin
                void'(mem_q.pop_front());
                mem_beat = '0;
            end else begin
                mem_beat++;
            end
        end
        if (!m_axi_rvalid || m_axi_rready) begin  // a beat holds until it is taken
            if (mem_q.size() != 0 && ($random(seed) & 3) != 0) begin
                m_axi_rvalid <= 1'b1;
                m_axi_rid    <= mem_q[0].id;
                m_axi_rdata  <= mem_q[0].addr + axi_pkg::addr_t'(mem_beat);
                m_axi_rresp  <= axi_pkg::RESP_OKAY;
                m_axi_rlast  <= (mem_beat == mem_q[0].len);
            end else begin
                m_axi_rvalid <= 1'b0;
            end
        end
    endtask

    task consume_read;
        rd_req_t        cur;
        axi_pkg::data_t exp_data;
        axi_pkg::resp_t exp_resp;
        if (s_axi_rvalid && s_axi_rready) begin
            if (resp_q.size() == 0) begin
                $display("read beat arrived with no request outstanding");
                fail_run();
            end else begin
                cur = resp_q[0];
                if (cur.addr[DROP_BIT]) begin
                    exp_data = '0;
                    exp_resp = axi_pkg::RESP_SLVERR;
                end else begin
                    exp_data = (cur.addr ^ ADDR_MASK) + axi_pkg::addr_t'(r_beat);
                    exp_resp = axi_pkg::RESP_OKAY;
                end
                check_r($sformatf("request %0d beat %0d", done_count, r_beat), cur.id, s_axi_rid,
                        exp_data, s_axi_rdata, exp_resp, s_axi_rresp,
                        r_beat == cur.len, s_axi_rlast);
                if (r_beat == cur.len) begin
                    void'(resp_q.pop_front());
                    r_beat = '0;
                    done_count++;
                end else begin
                    r_beat++;
                end
            end
        end
        s_axi_rready <= ($random(seed) & 3) != 0;
    endtask

    initial begin
        s_axi_clk = 1'b0;
        forever #10 s_axi_clk = ~s_axi_clk;
    end

    // one process runs every agent in a fixed order each cycle
    always @(posedge s_axi_clk) begin
        if (s_aresetn) begin
            drive_master();
            answer_xlat();
            serve_memory();
            consume_read();
        end
    end

    always @(posedge s_axi_clk) begin
        cycle++;
        if (cycle >= 2 && cycle <= 5) begin  // reset cycles and the two after release
            check_quiet($sformatf("reset cycle %0d", cycle), s_axi_rvalid, m_axi_arvalid,
                        xlat_req_valid);
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d requests answered",
                     cycle, done_count, NUM_REQS);
            fail_run();
        end
    end

    initial begin
        seed = 32'h2f3d_0970;
        s_aresetn       <= 1'b0;
        s_axi_arid      <= '0;
        s_axi_araddr    <= '0;
        s_axi_arlen     <= '0;
        s_axi_arsize    <= '0;
        s_axi_arburst   <= '0;
        s_axi_arprot    <= '0;
        s_axi_arvalid   <= 1'b0;
        s_axi_rready    <= 1'b0;
        m_axi_arready   <= 1'b0;
        m_axi_rid       <= '0;
        m_axi_rdata     <= '0;
        m_axi_rresp     <= axi_pkg::RESP_OKAY;
        m_axi_rlast     <= 1'b0;
        m_axi_rvalid    <= 1'b0;
        xlat_req_ready  <= 1'b0;
        xlat_resp_valid <= 1'b0;
        xlat_resp_done  <= 1'b0;
        xlat_resp_addr  <= '0;
        repeat (3) @(posedge s_axi_clk);
        s_aresetn <= 1'b1;
        wait (done_count == NUM_REQS);
        repeat (20) @(posedge s_axi_clk);  // a stray beat in this window still fails
        if (ar_q.size() != 0 || resp_q.size() != 0 || mem_q.size() != 0 ||
            xlat_q.size() != 0) begin
            $display("requests still queued after the last expected response");
            fail_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/axi_pkg.sv
hw/xlat_pkg.sv
hw/ar_req_if.sv
hw/drop_if.sv
hw/ar_queue.sv
hw/xlat_ctrl.sv
hw/r_return.sv
hw/mmu_read_top.sv
bench/tb_mmu_read.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mmu_read
FILELIST   := src.f
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
SOURCES    := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
